//--- verilog/mbus_frame_pkg.sv
package mbus_frame_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 32;
	localparam int frame_bits = 1 + addr_width + data_width;	// start + addr + data

	// unicast view of the address byte
	typedef struct packed {
		logic [addr_width/2-1:0]	prefix;
		logic [addr_width/2-1:0]	fid;
	} mbus_ucast_t;

	// broadcast view, upper nibble is zero
	typedef struct packed {
		logic [addr_width/2-1:0]	zero;
		logic [addr_width/2-1:0]	channel;
	} mbus_bcast_t;

	typedef union packed {
		mbus_ucast_t	ucast;
		mbus_bcast_t	bcast;
	} mbus_addr_u;

	typedef struct packed {
		mbus_addr_u				addr;
		logic [data_width-1:0]	data;
	} mbus_frame_t;

	typedef struct packed {
		mbus_frame_t	frame;
		logic			valid;	// one cycle strobe
	} mbus_tx_req_t;

endpackage

//--- verilog/mbus_power_pkg.sv
package mbus_power_pkg;

	// wake sequence, one state per released signal
	typedef enum logic [2:0] {
		pwr_sleep,
		pwr_on,
		pwr_clk,
		pwr_rst,
		pwr_awake
	} pwr_state_e;

	typedef struct packed {
		logic	power_on;
		logic	release_clk;
		logic	release_rst;
		logic	release_iso;
	} mbus_pwr_t;

	localparam int wake_step = 4;	// cycles between sequence steps

	// broadcast channel carrying the sleep command
	localparam logic [3:0] sleep_channel = 4'd1;

endpackage

//--- verilog/mbus_sleep_ctrl.sv
`timescale 1ns/1ns

module mbus_sleep_ctrl
	import mbus_power_pkg::*;
(
	input	logic		clk_ext,
	input	logic		rst_n,
	input	logic		wake_req,
	input	logic		sleep_req,
	output	mbus_pwr_t	pwr
);

pwr_state_e						state;
logic [$clog2(wake_step)-1:0]	step_cnt;
logic							step_end;

assign step_end = int'(step_cnt) == wake_step - 1;

always_ff @(posedge clk_ext or negedge rst_n)
begin
	if (!rst_n)
	begin
		state <= pwr_sleep;
		step_cnt <= '0;
	end
	else if (sleep_req)
	begin
		// drop everything at once
		state <= pwr_sleep;
		step_cnt <= '0;
	end
	else
	begin
		case (state)
			pwr_sleep:
			begin
				step_cnt <= '0;
				if (wake_req)
					state <= pwr_on;
			end
			pwr_on, pwr_clk, pwr_rst:
			begin
				step_cnt <= step_cnt + 1'b1;
				if (step_end)
				begin
					step_cnt <= '0;
					if (state == pwr_on)
						state <= pwr_clk;
					else if (state == pwr_clk)
						state <= pwr_rst;
					else
						state <= pwr_awake;
				end
			end
			default:
				step_cnt <= '0;	// awake, extra wake requests ignored
		endcase
	end
end

always_comb
begin
	pwr.power_on = state != pwr_sleep;
	pwr.release_clk = state inside {pwr_clk, pwr_rst, pwr_awake};
	pwr.release_rst = state inside {pwr_rst, pwr_awake};
	pwr.release_iso = state == pwr_awake;
end

endmodule

//--- verilog/mbus_wake_req.sv
`timescale 1ns/1ns

module mbus_wake_req
	import mbus_power_pkg::*;
(
	input	logic		clk_ext,
	input	logic		rst_n,
	input	logic		din,
	input	logic		req_int,
	input	mbus_pwr_t	pwr,
	output	logic		wake_req
);

logic	ring_start;

// start bit while the gated domain is off
assign ring_start = !din && !pwr.power_on;

// sticky until the layer sees the bus released
always_ff @(posedge clk_ext or negedge rst_n)
begin
	if (!rst_n)
		wake_req <= 1'b0;
	else if (pwr.release_iso)
		wake_req <= 1'b0;
	else if (req_int || ring_start)
		wake_req <= 1'b1;
end

endmodule

//--- verilog/mbus_frame_engine.sv
`timescale 1ns/1ns

module mbus_frame_engine
	import mbus_frame_pkg::*, mbus_power_pkg::*;
#(
	parameter logic [3:0] node_prefix = 4'ha
)
(
	input	logic			clk_ext,
	input	logic			rst_n,
	input	mbus_pwr_t		pwr,
	input	logic			din,
	input	mbus_tx_req_t	tx_req,
	output	mbus_frame_t	rx_frame,
	output	logic			rx_strobe,
	output	logic			rx_bcast,
	output	logic			tx_done,
	output	logic			tx_err,
	output	logic			sleep_req,
	output	logic			tx_active,
	output	logic			tx_bit
);

logic							en;
logic							rx_busy;
logic [$clog2(frame_bits)-1:0]	rx_cnt;
logic [$clog2(frame_bits)-1:0]	idle_cnt;	// consecutive high samples, saturating
logic							synced;
mbus_frame_t					rx_sr;
mbus_frame_t					rx_next;
logic							rx_start, rx_last, rx_hit, rx_is_bcast;
logic							tx_busy;
logic [$clog2(frame_bits)-1:0]	tx_cnt;
logic [frame_bits-1:0]			tx_sr;
logic							tx_ok, tx_last, line_idle;

assign en = pwr.power_on & pwr.release_rst;

assign rx_next = {rx_sr[addr_width+data_width-2:0], din};
assign rx_is_bcast = rx_next.addr.bcast.zero == '0;
assign rx_hit = rx_is_bcast || rx_next.addr.ucast.prefix == node_prefix;
// a start is trusted only once the ring was seen idle for a whole frame
assign rx_start = synced && !din && !rx_busy && !tx_busy;
assign rx_last = rx_busy && int'(rx_cnt) == frame_bits - 2;

assign line_idle = din && idle_cnt != '0;
assign tx_ok = tx_req.valid && pwr.release_iso && synced && line_idle && !rx_busy && !tx_busy;
assign tx_last = tx_busy && int'(tx_cnt) == frame_bits - 1;

assign rx_frame = rx_sr;
assign tx_active = tx_busy;
assign tx_bit = tx_sr[frame_bits-1];	// msb first

always_ff @(posedge clk_ext or negedge rst_n)
begin
	if (!rst_n)
	begin
		rx_busy <= 1'b0;
		rx_cnt <= '0;
		idle_cnt <= '0;
		synced <= 1'b0;
		rx_strobe <= 1'b0;
		rx_bcast <= 1'b0;
		sleep_req <= 1'b0;
	end
	else if (!en)
	begin
		rx_busy <= 1'b0;
		rx_cnt <= '0;
		idle_cnt <= '0;
		synced <= 1'b0;
		rx_strobe <= 1'b0;
		rx_bcast <= 1'b0;
		sleep_req <= 1'b0;
	end
	else
	begin
		rx_strobe <= 1'b0;
		sleep_req <= 1'b0;
		if (!din)
			idle_cnt <= '0;
		else if (int'(idle_cnt) < frame_bits - 1)
			idle_cnt <= idle_cnt + 1'b1;
		if (int'(idle_cnt) == frame_bits - 1)
			synced <= 1'b1;
		if (rx_start)
		begin
			rx_busy <= 1'b1;
			rx_cnt <= '0;
		end
		else if (rx_busy)
		begin
			rx_cnt <= rx_cnt + 1'b1;
			if (rx_last)
			begin
				rx_busy <= 1'b0;
				rx_strobe <= rx_hit;
				rx_bcast <= rx_is_bcast;
				sleep_req <= rx_is_bcast && rx_next.addr.bcast.channel == sleep_channel;
			end
		end
	end
end

always_ff @(posedge clk_ext or negedge rst_n)
begin
	if (!rst_n)
	begin
		tx_busy <= 1'b0;
		tx_cnt <= '0;
		tx_done <= 1'b0;
		tx_err <= 1'b0;
	end
	else if (!en)
	begin
		tx_busy <= 1'b0;
		tx_cnt <= '0;
		tx_done <= 1'b0;
		tx_err <= 1'b0;
	end
	else
	begin
		tx_done <= tx_last;
		tx_err <= tx_req.valid && !tx_ok;	// busy line or rx in progress
		if (tx_ok)
		begin
			tx_busy <= 1'b1;
			tx_cnt <= '0;
		end
		else if (tx_busy)
		begin
			tx_cnt <= tx_cnt + 1'b1;
			if (tx_last)
				tx_busy <= 1'b0;
		end
	end
end

always_ff @(posedge clk_ext)
begin
	if (rx_busy)
		rx_sr <= rx_next;
	if (tx_ok)
		tx_sr <= {1'b0, tx_req.frame};	// start bit first
	else if (tx_busy)
		tx_sr <= {tx_sr[frame_bits-2:0], 1'b1};
end

endmodule

//--- verilog/mbus_isolation.sv
`timescale 1ns/1ns

module mbus_isolation
	import mbus_frame_pkg::*, mbus_power_pkg::*;
(
	input	mbus_pwr_t		pwr,
	input	mbus_frame_t	rx_frame,
	input	logic			rx_strobe,
	input	logic			rx_bcast,
	input	logic			tx_done,
	input	logic			tx_err,
	input	mbus_tx_req_t	tx_req_lc,
	output	mbus_frame_t	rx,
	output	logic			rx_req,
	output	logic			rx_broadcast,
	output	logic			tx_succ,
	output	logic			tx_fail,
	output	mbus_tx_req_t	tx_req_bc,
	output	mbus_pwr_t		lc_pwr
);

// layer bound, clamped while the gated side is isolated
always_comb
begin
	if (pwr.release_iso)
	begin
		rx = rx_frame;
		rx_req = rx_strobe;
		rx_broadcast = rx_bcast;
		tx_succ = tx_done;
		tx_fail = tx_err;
	end
	else
	begin
		rx = '0;
		rx_req = 1'b0;
		rx_broadcast = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
	end
end

// request silently dropped during isolation
assign tx_req_bc = pwr.release_iso ? tx_req_lc : '0;

assign lc_pwr = pwr;

endmodule

//--- verilog/mbus_wire_ctrl.sv
`timescale 1ns/1ns

module mbus_wire_ctrl
(
	input	logic	clk_ext,
	input	logic	rst_n,
	input	logic	din,
	input	logic	tx_active,
	input	logic	tx_bit,
	output	logic	dout
);

logic	fwd_q;	// one cycle ring delay

always_ff @(posedge clk_ext or negedge rst_n)
begin
	if (!rst_n)
		fwd_q <= 1'b1;	// ring idles high
	else
		fwd_q <= din;
end

// node owns the line while sending
assign dout = tx_active ? tx_bit : fwd_q;

endmodule

//--- verilog/mbus_layer_wrapper.sv
`timescale 1ns/1ns

module mbus_layer_wrapper
	import mbus_frame_pkg::*, mbus_power_pkg::*;
#(
	parameter logic [3:0] node_prefix = 4'ha
)
(
	input	logic			clk_ext,
	input	logic			rst_n,
	input	logic			din,
	input	logic			req_int,
	input	mbus_tx_req_t	tx_req,
	output	logic			dout,
	output	mbus_frame_t	rx,
	output	logic			rx_req,
	output	logic			rx_broadcast,
	output	logic			tx_succ,
	output	logic			tx_fail,
	output	mbus_pwr_t		lc_pwr
);

mbus_pwr_t		pwr;
logic			wake_req, sleep_req;
mbus_frame_t	rx_frame;
logic			rx_strobe, rx_bcast, tx_done, tx_err;
logic			tx_active, tx_bit;
mbus_tx_req_t	tx_req_bc;

mbus_sleep_ctrl s0 (
	.clk_ext	(clk_ext),
	.rst_n		(rst_n),
	.wake_req	(wake_req),
	.sleep_req	(sleep_req),
	.pwr		(pwr)
);

// always on, sees the raw ring
mbus_wake_req wk0 (
	.clk_ext	(clk_ext),
	.rst_n		(rst_n),
	.din		(din),
	.req_int	(req_int),
	.pwr		(pwr),
	.wake_req	(wake_req)
);

// gated domain
mbus_frame_engine #(.node_prefix(node_prefix)) fe0 (
	.clk_ext	(clk_ext),
	.rst_n		(rst_n),
	.pwr		(pwr),
	.din		(din),
	.tx_req		(tx_req_bc),
	.rx_frame	(rx_frame),
	.rx_strobe	(rx_strobe),
	.rx_bcast	(rx_bcast),
	.tx_done	(tx_done),
	.tx_err		(tx_err),
	.sleep_req	(sleep_req),
	.tx_active	(tx_active),
	.tx_bit		(tx_bit)
);

mbus_isolation iso0 (
	.pwr			(pwr),
	.rx_frame		(rx_frame),
	.rx_strobe		(rx_strobe),
	.rx_bcast		(rx_bcast),
	.tx_done		(tx_done),
	.tx_err			(tx_err),
	.tx_req_lc		(tx_req),
	.rx				(rx),
	.rx_req			(rx_req),
	.rx_broadcast	(rx_broadcast),
	.tx_succ		(tx_succ),
	.tx_fail		(tx_fail),
	.tx_req_bc		(tx_req_bc),
	.lc_pwr			(lc_pwr)
);

mbus_wire_ctrl wc0 (
	.clk_ext	(clk_ext),
	.rst_n		(rst_n),
	.din		(din),
	.tx_active	(tx_active),
	.tx_bit		(tx_bit),
	.dout		(dout)
);

endmodule

//--- include/mbus_tb_model.svh
`ifndef mbus_tb_model_svh
`define mbus_tb_model_svh

// reference state, advanced once per clock
logic [31:0]	lcg_state = 32'd99149;
int				wake_age = -1;	// cycles since the wake trigger, -1 while asleep
logic			fwd_hist[$];	// din as seen one cycle back
logic			tx_exp[$];		// bits the node should drive
int				rx_due = 0;
int				succ_due = 0;
int				fail_due = 0;
mbus_frame_t	rx_exp;
logic			rx_exp_bcast;
logic			rx_exp_sleep;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// low bits of an lcg repeat too soon
function automatic int rand_range(input int lo, input int hi);
	return lo + int'(lcg_next() >> 8) % (hi - lo + 1);
endfunction

function automatic mbus_frame_t build_frame(input logic [3:0] hi, input logic [3:0] lo,
	input logic [31:0] data);
	mbus_frame_t	f;
	f.addr.ucast.prefix = hi;
	f.addr.ucast.fid = lo;
	f.data = data;
	return f;
endfunction

// wire order, start bit then msb first
function automatic logic serial_bit(input mbus_frame_t f, input int i);
	if (i == 0)
		return 1'b0;
	return f[addr_width+data_width-i];
endfunction

function automatic logic frame_hits(input mbus_frame_t f);
	return f.addr.ucast.prefix == node_prefix || f.addr.bcast.zero == 4'h0;
endfunction

// one cycle to latch the request, one to power on, then a release per step
function automatic mbus_pwr_t expected_pwr(input int n);
	mbus_pwr_t	p;
	p.power_on = n >= 2;
	p.release_clk = n >= 2 + wake_step;
	p.release_rst = n >= 2 + 2 * wake_step;
	p.release_iso = n >= 2 + 3 * wake_step;
	return p;
endfunction

function automatic logic model_awake();
	return wake_age >= 2 + 3 * wake_step;
endfunction

task automatic check_frame(input string name, input mbus_frame_t got, input mbus_frame_t exp);
	if (got !== exp)
		fail_stop($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_pwr(input string name, input mbus_pwr_t got, input mbus_pwr_t exp);
	if (got !== exp)
		fail_stop($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		fail_stop($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
endtask

`endif

//--- tests/tb_mbus_layer.sv
`timescale 1ns/1ns

module tb_mbus_layer
	import mbus_frame_pkg::*, mbus_power_pkg::*;
();

localparam logic [3:0]	node_prefix = 4'ha;
localparam int			wait_limit = 64;

logic			clk_ext = 1'b0;
logic			rst_n = 1'b0;
logic			din = 1'b1;
logic			req_int = 1'b0;
mbus_tx_req_t	tx_req = '0;
logic			dout;
mbus_frame_t	rx;
logic			rx_req;
logic			rx_broadcast;
logic			tx_succ;
logic			tx_fail;
mbus_pwr_t		lc_pwr;

always #20 clk_ext = ~clk_ext;

mbus_layer_wrapper #(.node_prefix(node_prefix)) dut0 (
	.clk_ext		(clk_ext),
	.rst_n			(rst_n),
	.din			(din),
	.req_int		(req_int),
	.tx_req			(tx_req),
	.dout			(dout),
	.rx				(rx),
	.rx_req			(rx_req),
	.rx_broadcast	(rx_broadcast),
	.tx_succ		(tx_succ),
	.tx_fail		(tx_fail),
	.lc_pwr			(lc_pwr)
);

task automatic fail_stop(input string msg);
	$display("%s", msg);
	$display("TEST FAILED");
	$fatal(1, "stopped at the first error");
endtask

`include "mbus_tb_model.svh"

// sampled mid cycle after the inputs settled
task automatic check_outputs();
	logic	exp_dout;
	if (wake_age >= 0)
		wake_age++;
	else if (din === 1'b0 || req_int === 1'b1)
		wake_age = 0;	// start bit or interrupt while asleep
	check_pwr("lc_pwr", lc_pwr, expected_pwr(wake_age));
	exp_dout = fwd_hist.pop_front();
	fwd_hist.push_back(din);
	if (tx_exp.size() > 0)
		exp_dout = tx_exp.pop_front();	// node owns the line
	check_bit("dout", dout, exp_dout);
	check_bit("rx_req", rx_req, rx_due == 1);
	if (rx_due == 1)
	begin
		check_frame("rx", rx, rx_exp);
		check_bit("rx_broadcast", rx_broadcast, rx_exp_bcast);
		if (rx_exp_sleep)
			wake_age = -1;
	end
	check_bit("tx_succ", tx_succ, succ_due == 1);
	check_bit("tx_fail", tx_fail, fail_due == 1);
	if (rx_due > 0)
		rx_due--;
	if (succ_due > 0)
		succ_due--;
	if (fail_due > 0)
		fail_due--;
endtask

task automatic run_cycle(input logic d, input logic irq, input mbus_tx_req_t req);
	@(posedge clk_ext);
	din <= d;
	req_int <= irq;
	tx_req <= req;
	@(negedge clk_ext);
	check_outputs();
endtask

task automatic idle_cycles(input int n);
	repeat (n)
		run_cycle(1'b1, 1'b0, '0);
endtask

// kind 0 own prefix, 1 broadcast off the sleep channel, else foreign
function automatic mbus_frame_t random_frame(input int kind);
	logic [3:0]	hi;
	logic [3:0]	lo;
	hi = 4'(rand_range(1, 15));
	lo = 4'(rand_range(0, 15));
	if (kind == 0)
		hi = node_prefix;
	else if (kind == 1)
	begin
		hi = 4'h0;
		if (lo == sleep_channel)
			lo = lo + 1'b1;
	end
	else if (hi == node_prefix)
		hi = hi + 1'b1;
	return build_frame(hi, lo, lcg_next());
endfunction

task automatic wait_rx();
	int	n;
	n = 0;
	do
	begin
		if (n == wait_limit)
			fail_stop("timeout, the node never raised rx_req");
		run_cycle(1'b1, 1'b0, '0);
		n++;
	end
	while (rx_req !== 1'b1);
endtask

// req_at is the bit index where a layer request collides or -1 for none
task automatic send_frame(input mbus_frame_t f, input int req_at);
	mbus_tx_req_t	req;
	mbus_tx_req_t	no_req;
	logic			hit;
	req.frame = random_frame(0);
	req.valid = 1'b1;
	no_req = '0;
	hit = model_awake() && frame_hits(f);
	for (int i = 0; i < frame_bits; i++)
	begin
		run_cycle(serial_bit(f, i), 1'b0, i == req_at ? req : no_req);
		if (i == 0 && hit)
		begin
			rx_due = frame_bits;
			rx_exp = f;
			rx_exp_bcast = f.addr.bcast.zero == 4'h0;
			rx_exp_sleep = rx_exp_bcast && f.addr.bcast.channel == sleep_channel;
		end
		if (i == req_at)
			fail_due = 1;
	end
	if (hit)
		wait_rx();
endtask

task automatic send_tx(input mbus_frame_t f);
	mbus_tx_req_t	req;
	int				n;
	req.frame = f;
	req.valid = 1'b1;
	run_cycle(1'b1, 1'b0, req);
	for (int i = 0; i < frame_bits; i++)
		tx_exp.push_back(serial_bit(f, i));
	succ_due = frame_bits + 1;
	n = 0;
	do
	begin
		if (n == wait_limit)
			fail_stop("timeout, the node never raised tx_succ");
		run_cycle(1'b1, 1'b0, '0);
		n++;
	end
	while (tx_succ !== 1'b1);
endtask

task automatic wait_awake();
	int	n;
	n = 0;
	while (lc_pwr.release_iso !== 1'b1)
	begin
		if (n == wait_limit)
			fail_stop("timeout, the wake sequence never released isolation");
		idle_cycles(1);
		n++;
	end
endtask

initial
begin
	fwd_hist.push_back(1'b1);	// ring idles high out of reset
	repeat (15)
		@(posedge clk_ext);
	@(negedge clk_ext);
	check_pwr("lc_pwr", lc_pwr, '0);
	check_bit("dout", dout, 1'b1);
	check_bit("rx_req", rx_req, 1'b0);
	check_bit("tx_succ", tx_succ, 1'b0);
	check_bit("tx_fail", tx_fail, 1'b0);
	@(posedge clk_ext);
	rst_n <= 1'b1;

	// first frame only wakes the node
	send_frame(random_frame(0), -1);
	wait_awake();
	idle_cycles(50);
	repeat (12)
	begin
		idle_cycles(rand_range(2, 9));
		send_frame(random_frame(rand_range(0, 2)), -1);
	end
	repeat (4)
	begin
		idle_cycles(rand_range(2, 9));
		send_tx(random_frame(rand_range(0, 2)));
	end
	idle_cycles(3);
	send_frame(random_frame(0), rand_range(5, 35));	// refused mid frame
	idle_cycles(4);
	send_frame(build_frame(4'h0, sleep_channel, lcg_next()), -1);
	idle_cycles(4);
	// isolation swallows the request while asleep
	run_cycle(1'b1, 1'b0, {random_frame(0), 1'b1});
	idle_cycles(50);
	run_cycle(1'b1, 1'b1, '0);
	wait_awake();
	idle_cycles(50);
	send_frame(random_frame(1), -1);
	idle_cycles(2);
	send_tx(random_frame(0));
	idle_cycles(4);

	$display("TEST OK");
	$finish;
end

endmodule

//--- list.f
+incdir+include
verilog/mbus_frame_pkg.sv
verilog/mbus_power_pkg.sv
verilog/mbus_sleep_ctrl.sv
verilog/mbus_wake_req.sv
verilog/mbus_frame_engine.sv
verilog/mbus_isolation.sv
verilog/mbus_wire_ctrl.sv
verilog/mbus_layer_wrapper.sv
tests/tb_mbus_layer.sv
